// File: llc_defines.svh
// widths and map reset values for the llc front end; line size must be a power of two
`ifndef LLC_DEFINES_SVH
`define LLC_DEFINES_SVH

// axi address vector widths
`define LLC_ADDR_W 32
`define LLC_ID_W 4
`define LLC_LEN_W 8

// cache line size in bytes
`define LLC_LINE_BYTES 32

// address map after reset
// cached window is [start, end), everything at or above the spm start is scratchpad
`define LLC_CACHED_START_RST 32'h0000_0000
`define LLC_CACHED_END_RST 32'h8000_0000
`define LLC_SPM_START_RST 32'hC000_0000

`endif

// File: llc_axi_pkg.sv
// axi4 address channel types only; no user, cache, prot, qos or region fields
`include "llc_defines.svh"

package llc_axi_pkg;

  // burst encodings as on the axi bus
  // FIXED and WRAP get cut like INCR downstream
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // one AW or AR address vector
  typedef struct packed {
    logic [`LLC_ID_W-1:0]   id;
    logic [`LLC_ADDR_W-1:0] addr;
    // beats minus one
    logic [`LLC_LEN_W-1:0]  len;
    // log2 of bytes per beat
    logic [2:0]             size;
    burst_e                 burst;
  } ax_chan_t;

endpackage

// File: llc_desc_pkg.sv
// descriptor, address rule and wishbone classic types; rules hold byte addresses
`include "llc_defines.svh"

package llc_desc_pkg;

  // one access that stays inside a single cache line
  typedef struct packed {
    logic [`LLC_ADDR_W-1:0] addr;
    logic [`LLC_ID_W-1:0]   id;
    // beats in this line minus one
    logic [`LLC_LEN_W-1:0]  x_len;
    // last descriptor of its axi vector
    logic                   x_last;
    logic                   x_write;
    logic                   spm;
    logic                   bypass;
  } llc_desc_t;

  // address window, end is exclusive
  typedef struct packed {
    logic [`LLC_ADDR_W-1:0] start_addr;
    logic [`LLC_ADDR_W-1:0] end_addr;
  } addr_rule_t;

  // wishbone classic master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  // wishbone classic slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

// File: llc_burst_cutter.sv
// combinational only; assumes 2^size <= line bytes, unaligned starts round down to the beat
`timescale 1ns/1ns
`include "llc_defines.svh"

module llc_burst_cutter #(
  parameter type chan_t = llc_axi_pkg::ax_chan_t,
  parameter bit  Write  = 1'b1
) (
  input  chan_t                    curr_chan_i,
  output chan_t                    next_chan_o,
  output llc_desc_pkg::llc_desc_t  desc_o,
  input  llc_desc_pkg::addr_rule_t cached_rule_i,
  input  llc_desc_pkg::addr_rule_t spm_rule_i
);
  localparam int unsigned AddrW    = `LLC_ADDR_W;
  localparam int unsigned LenW     = `LLC_LEN_W;
  localparam int unsigned LineOffW = $clog2(`LLC_LINE_BYTES);
  // one extra bit so a full line (offset zero) still fits
  localparam int unsigned BeatW    = LineOffW + 1;
  localparam int unsigned CntW     = LenW + 1;

  logic [LineOffW-1:0] line_off;
  logic [LineOffW-1:0] beat_mask;
  logic [BeatW-1:0]    bytes_to_line;
  logic [BeatW-1:0]    beats_to_line;
  logic [CntW-1:0]     total_beats;
  logic                fits_line;
  logic                is_spm;
  logic                is_bypass;

  always_comb begin
    // byte position inside the line, rounded down to the beat
    line_off      = curr_chan_i.addr[LineOffW-1:0];
    beat_mask     = LineOffW'((32'd1 << curr_chan_i.size) - 32'd1);
    bytes_to_line = BeatW'(`LLC_LINE_BYTES) - {1'b0, line_off & ~beat_mask};
    beats_to_line = bytes_to_line >> curr_chan_i.size;
    // len counts beats minus one
    total_beats   = {1'b0, curr_chan_i.len} + CntW'(1);
    fits_line     = total_beats <= CntW'(beats_to_line);

    // spm wins over the cached window
    is_spm    = curr_chan_i.addr >= spm_rule_i.start_addr;
    is_bypass = !is_spm &&
                ((curr_chan_i.addr < cached_rule_i.start_addr) ||
                 (curr_chan_i.addr >= cached_rule_i.end_addr));

    // fields common to every descriptor
    desc_o.addr    = curr_chan_i.addr;
    desc_o.id      = curr_chan_i.id;
    desc_o.x_write = Write;
    desc_o.spm     = is_spm;
    desc_o.bypass  = is_bypass;

    // remainder defaults to the current vector, only meaningful when not last
    next_chan_o = curr_chan_i;

    if (is_bypass || fits_line) begin
      // bypass goes out whole, never cut at line boundaries
      desc_o.x_len  = curr_chan_i.len;
      desc_o.x_last = 1'b1;
    end else begin
      // stop at the line end, rest continues from the next line start
      desc_o.x_len     = LenW'(beats_to_line - BeatW'(1));
      desc_o.x_last    = 1'b0;
      next_chan_o.addr = {curr_chan_i.addr[AddrW-1:LineOffW], {LineOffW{1'b0}}} +
                         AddrW'(`LLC_LINE_BYTES);
      next_chan_o.len  = curr_chan_i.len - LenW'(beats_to_line);
    end
  end

endmodule

// File: llc_chan_splitter.sv
// one vector in flight; a new vector is taken on the last descriptor handshake only
`timescale 1ns/1ns
`include "llc_defines.svh"

module llc_chan_splitter #(
  parameter type chan_t = llc_axi_pkg::ax_chan_t,
  parameter bit  Write  = 1'b1
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // axi address side
  input  chan_t                    ax_chan_i,
  input  logic                     ax_valid_i,
  output logic                     ax_ready_o,
  // descriptor side
  output llc_desc_pkg::llc_desc_t  desc_o,
  output logic                     desc_valid_o,
  input  logic                     desc_ready_i,
  // holding or presenting a vector
  output logic                     busy_o,
  // address map
  input  llc_desc_pkg::addr_rule_t cached_rule_i,
  input  llc_desc_pkg::addr_rule_t spm_rule_i
);
  chan_t chan_d;
  chan_t chan_q;
  logic  load_chan;
  logic  busy_d;
  logic  busy_q;
  logic  load_busy;
  // vector being cut this cycle and what is left after it
  chan_t curr_chan;
  chan_t next_chan;

  always_comb begin
    curr_chan    = ax_chan_i;
    chan_d       = chan_q;
    load_chan    = 1'b0;
    busy_d       = busy_q;
    load_busy    = 1'b0;
    ax_ready_o   = 1'b0;
    desc_valid_o = 1'b0;
    busy_o       = 1'b0;

    if (busy_q) begin
      // serve the stored remainder
      curr_chan    = chan_q;
      desc_valid_o = 1'b1;
      busy_o       = 1'b1;
      if (desc_ready_i) begin
        if (desc_o.x_last) begin
          // last piece leaves, accept the next vector back to back
          ax_ready_o = 1'b1;
          if (ax_valid_i) begin
            chan_d    = ax_chan_i;
            load_chan = 1'b1;
          end else begin
            busy_d    = 1'b0;
            load_busy = 1'b1;
          end
        end else begin
          chan_d    = next_chan;
          load_chan = 1'b1;
        end
      end
    end else begin
      // idle, incoming vector passes straight to the cutter
      ax_ready_o = 1'b1;
      if (ax_valid_i) begin
        desc_valid_o = 1'b1;
        busy_o       = 1'b1;
        if (desc_ready_i) begin
          // first piece gone, keep the rest if any
          if (!desc_o.x_last) begin
            chan_d    = next_chan;
            load_chan = 1'b1;
            busy_d    = 1'b1;
            load_busy = 1'b1;
          end
        end else begin
          // stalled, park the whole vector so the descriptor stays stable
          chan_d    = ax_chan_i;
          load_chan = 1'b1;
          busy_d    = 1'b1;
          load_busy = 1'b1;
        end
      end
    end
  end

  llc_burst_cutter #(
    .chan_t ( chan_t ),
    .Write  ( Write  )
  ) i_burst_cutter (
    .curr_chan_i   ( curr_chan     ),
    .next_chan_o   ( next_chan     ),
    .desc_o        ( desc_o        ),
    .cached_rule_i ( cached_rule_i ),
    .spm_rule_i    ( spm_rule_i    )
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (load_busy) begin
      busy_q <= busy_d;
    end
  end

  // vector register, only read while busy_q is set
  always_ff @(posedge clk_i) begin
    if (load_chan) begin
      chan_q <= chan_d;
    end
  end

endmodule

// File: llc_desc_arbiter.sv
// two inputs only; grant is held while a presented descriptor waits for ready
`timescale 1ns/1ns
`include "llc_defines.svh"

module llc_desc_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // write splitter
  input  llc_desc_pkg::llc_desc_t wr_desc_i,
  input  logic                    wr_valid_i,
  output logic                    wr_ready_o,
  // read splitter
  input  llc_desc_pkg::llc_desc_t rd_desc_i,
  input  logic                    rd_valid_i,
  output logic                    rd_ready_o,
  // merged stream
  output llc_desc_pkg::llc_desc_t desc_o,
  output logic                    desc_valid_o,
  input  logic                    desc_ready_i
);
  // 0 favours write, 1 favours read
  logic prio_q;
  // grant frozen while a descriptor is stalled
  logic lock_q;
  logic lock_sel_q;
  // 0 selects write, 1 selects read
  logic sel;

  always_comb begin
    if (lock_q) begin
      sel = lock_sel_q;
    end else if (wr_valid_i && rd_valid_i) begin
      sel = prio_q;
    end else begin
      // single requester or none
      sel = rd_valid_i;
    end

    // no added latency, pure mux
    desc_o       = sel ? rd_desc_i : wr_desc_i;
    desc_valid_o = sel ? rd_valid_i : wr_valid_i;
    wr_ready_o   = !sel && desc_ready_i;
    rd_ready_o   = sel && desc_ready_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
    end else begin
      lock_q     <= desc_valid_o && !desc_ready_i;
      lock_sel_q <= sel;
      // turn over priority on every accepted descriptor
      if (desc_valid_o && desc_ready_i) begin
        prio_q <= ~prio_q;
      end
    end
  end

endmodule

// File: llc_addr_map_regs.sv
// wishbone classic, no wait states beyond the one-cycle ack; register 3 reads zero
`timescale 1ns/1ns
`include "llc_defines.svh"

module llc_addr_map_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  llc_desc_pkg::wb_req_t    wb_i,
  output llc_desc_pkg::wb_rsp_t    wb_o,
  output llc_desc_pkg::addr_rule_t cached_rule_o,
  output llc_desc_pkg::addr_rule_t spm_rule_o
);
  logic [`LLC_ADDR_W-1:0] cached_start_q;
  logic [`LLC_ADDR_W-1:0] cached_end_q;
  logic [`LLC_ADDR_W-1:0] spm_start_q;
  logic                   ack_q;
  logic [31:0]            rdata;
  logic [31:0]            rdata_q;
  // new request, not the cycle the ack is already out
  logic                   req;

  assign req = wb_i.cyc && wb_i.stb && !ack_q;

  // read mux
  always_comb begin
    case (wb_i.adr)
      2'd0:    rdata = cached_start_q;
      2'd1:    rdata = cached_end_q;
      2'd2:    rdata = spm_start_q;
      default: rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q          <= 1'b0;
      cached_start_q <= `LLC_CACHED_START_RST;
      cached_end_q   <= `LLC_CACHED_END_RST;
      spm_start_q    <= `LLC_SPM_START_RST;
    end else begin
      ack_q <= req;
      // write lands together with the ack
      if (req && wb_i.we) begin
        case (wb_i.adr)
          2'd0:    cached_start_q <= wb_i.dat;
          2'd1:    cached_end_q   <= wb_i.dat;
          2'd2:    spm_start_q    <= wb_i.dat;
          default: ;
        endcase
      end
    end
  end

  // read data captured with the request, valid while ack is high
  always_ff @(posedge clk_i) begin
    if (req) begin
      rdata_q <= rdata;
    end
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rdata_q;

  assign cached_rule_o.start_addr = cached_start_q;
  assign cached_rule_o.end_addr   = cached_end_q;
  // spm window runs to the top of the address space
  assign spm_rule_o.start_addr    = spm_start_q;
  assign spm_rule_o.end_addr      = '1;

endmodule

// File: llc_split_top.sv
// INCR cutting only, no data channels; busy_o only reports vectors held in the splitters
`timescale 1ns/1ns
`include "llc_defines.svh"

module llc_split_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // AW
  input  llc_axi_pkg::ax_chan_t   aw_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  // AR
  input  llc_axi_pkg::ax_chan_t   ar_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  // descriptors to the cache pipeline
  output llc_desc_pkg::llc_desc_t desc_o,
  output logic                    desc_valid_o,
  input  logic                    desc_ready_i,
  output logic                    busy_o,
  // map registers
  input  llc_desc_pkg::wb_req_t   wb_i,
  output llc_desc_pkg::wb_rsp_t   wb_o
);
  import llc_axi_pkg::*;
  import llc_desc_pkg::*;

  addr_rule_t cached_rule;
  addr_rule_t spm_rule;
  llc_desc_t  wr_desc;
  logic       wr_valid;
  logic       wr_ready;
  logic       wr_busy;
  llc_desc_t  rd_desc;
  logic       rd_valid;
  logic       rd_ready;
  logic       rd_busy;

  llc_addr_map_regs i_addr_map_regs (
    .clk_i, .rst_n_i, .wb_i, .wb_o,
    .cached_rule_o ( cached_rule ),
    .spm_rule_o    ( spm_rule    )
  );

  llc_chan_splitter #(.chan_t(ax_chan_t), .Write(1'b1)) i_aw_splitter (
    .clk_i, .rst_n_i,
    .ax_chan_i (aw_i), .ax_valid_i (aw_valid_i), .ax_ready_o (aw_ready_o),
    .desc_o (wr_desc), .desc_valid_o (wr_valid), .desc_ready_i (wr_ready),
    .busy_o (wr_busy), .cached_rule_i (cached_rule), .spm_rule_i (spm_rule)
  );

  llc_chan_splitter #(.chan_t(ax_chan_t), .Write(1'b0)) i_ar_splitter (
    .clk_i, .rst_n_i,
    .ax_chan_i (ar_i), .ax_valid_i (ar_valid_i), .ax_ready_o (ar_ready_o),
    .desc_o (rd_desc), .desc_valid_o (rd_valid), .desc_ready_i (rd_ready),
    .busy_o (rd_busy), .cached_rule_i (cached_rule), .spm_rule_i (spm_rule)
  );

  llc_desc_arbiter i_desc_arbiter (
    .clk_i, .rst_n_i,
    .wr_desc_i (wr_desc), .wr_valid_i (wr_valid), .wr_ready_o (wr_ready),
    .rd_desc_i (rd_desc), .rd_valid_i (rd_valid), .rd_ready_o (rd_ready),
    .desc_o, .desc_valid_o, .desc_ready_i
  );

  // either direction still has work
  assign busy_o = wr_busy | rd_busy;

endmodule

// File: llc_split_assertions.sv
// bound to every llc_chan_splitter; assumes 32 byte lines and a master that holds valid until ready
`timescale 1ns/1ns
`include "llc_defines.svh"

module llc_split_assertions (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input llc_axi_pkg::ax_chan_t   ax_chan_i,
  input logic                    ax_valid_i,
  input logic                    ax_ready_o,
  input llc_axi_pkg::ax_chan_t   curr_chan_i,
  input llc_desc_pkg::llc_desc_t desc_o,
  input logic                    desc_valid_o,
  input logic                    desc_ready_i
);
  localparam int unsigned OffW = $clog2(`LLC_LINE_BYTES);

  logic [OffW-1:0] start_off;
  logic [19:0]     end_off;
  logic            fits;

  // byte span of the vector under the cutter, from its beat-aligned start
  always_comb begin
    start_off = curr_chan_i.addr[OffW-1:0] &
                ~OffW'((32'd1 << curr_chan_i.size) - 32'd1);
    end_off   = 20'(start_off) +
                (20'({1'b0, curr_chan_i.len} + 9'd1) << curr_chan_i.size);
    // last byte still inside the same line
    fits      = end_off <= 20'(`LLC_LINE_BYTES);
  end

  // a waiting vector must not change
  ax_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ax_valid_i && !ax_ready_o |=> ax_valid_i && $stable(ax_chan_i))
    else $error("address vector changed while waiting for ready");

  // stalled descriptor stays put
  desc_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    desc_valid_o && !desc_ready_i |=> desc_valid_o && $stable(desc_o))
    else $error("descriptor changed while stalled");

  // whole vector inside one line is always the last piece
  last_on_fit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    desc_valid_o && fits |-> desc_o.x_last)
    else $error("x_last missing on a vector that fits its line");

endmodule

bind llc_chan_splitter llc_split_assertions i_split_assertions (
  .clk_i        ( clk_i        ),
  .rst_n_i      ( rst_n_i      ),
  .ax_chan_i    ( ax_chan_i    ),
  .ax_valid_i   ( ax_valid_i   ),
  .ax_ready_o   ( ax_ready_o   ),
  .curr_chan_i  ( curr_chan    ),
  .desc_o       ( desc_o       ),
  .desc_valid_o ( desc_valid_o ),
  .desc_ready_i ( desc_ready_i )
);

// File: tb_llc_split.sv
// trace driven; expects E records of a vector before its V record, P groups run AW and AR together
`timescale 1ns/1ns
`include "llc_defines.svh"

module tb_llc_split;
  import llc_axi_pkg::*;
  import llc_desc_pkg::*;

  logic      clk;
  logic      rst_n_i;
  ax_chan_t  aw_i;
  logic      aw_valid_i;
  logic      aw_ready_o;
  ax_chan_t  ar_i;
  logic      ar_valid_i;
  logic      ar_ready_o;
  llc_desc_t desc_o;
  logic      desc_valid_o;
  logic      desc_ready_i;
  logic      busy_o;
  wb_req_t   wb_i;
  wb_rsp_t   wb_o;

  integer    seed = 32'hf01ccf68;
  int        n_records;
  int        error_count;
  // expected descriptors per direction
  llc_desc_t exp_wr_q[$];
  llc_desc_t exp_rd_q[$];
  // vectors not yet driven
  ax_chan_t  aw_q[$];
  ax_chan_t  ar_q[$];
  logic      wr_last_hs;
  // merged descriptor seen stalled at the previous edge
  llc_desc_t held_desc;
  logic      held_stall;

  llc_split_top dut0 (
    .clk_i (clk), .rst_n_i, .aw_i, .aw_valid_i, .aw_ready_o,
    .ar_i, .ar_valid_i, .ar_ready_o, .desc_o, .desc_valid_o,
    .desc_ready_i, .busy_o, .wb_i, .wb_o
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // consumer back-pressure, ready about three cycles in four
  always @(posedge clk) begin
    desc_ready_i <= ($random(seed) & 3) != 0;
  end

  // scoreboard on every accepted descriptor
  always @(posedge clk) begin
    llc_desc_t exp;
    wr_last_hs = desc_valid_o && desc_ready_i && desc_o.x_write && desc_o.x_last;
    if (rst_n_i) begin
      if (desc_valid_o) check("busy while presenting", busy_o, 1);
      // AW stays closed until the last write piece leaves
      if (dut0.i_aw_splitter.busy_q && !wr_last_hs) check("aw_ready while pending", aw_ready_o, 0);
      // arbiter keeps its grant, so the merged output holds while stalled
      if (held_stall) begin
        check("desc_valid under stall", desc_valid_o, 1);
        check("desc under stall", desc_o, held_desc);
      end
      if (desc_valid_o && desc_ready_i) begin
        if ((desc_o.x_write && exp_wr_q.size() == 0) ||
            (!desc_o.x_write && exp_rd_q.size() == 0)) begin
          $display("descriptor accepted at %0t but none was expected", $time);
          $display("Simulation finished: FAIL");
          $fatal(1, "unexpected descriptor");
        end
        exp = desc_o.x_write ? exp_wr_q.pop_front() : exp_rd_q.pop_front();
        check("addr", desc_o.addr, exp.addr);
        check("id", desc_o.id, exp.id);
        check("x_len", desc_o.x_len, exp.x_len);
        check("x_last", desc_o.x_last, exp.x_last);
        check("spm", desc_o.spm, exp.spm);
        check("bypass", desc_o.bypass, exp.bypass);
      end
    end
    held_stall = rst_n_i && desc_valid_o && !desc_ready_i;
    held_desc  = desc_o;
  end

  task automatic send_aw(input ax_chan_t v);
    @(posedge clk);
    aw_i       <= v;
    aw_valid_i <= 1'b1;
    do @(posedge clk); while (!aw_ready_o);
    aw_valid_i <= 1'b0;
  endtask

  task automatic send_ar(input ax_chan_t v);
    @(posedge clk);
    ar_i       <= v;
    ar_valid_i <= 1'b1;
    do @(posedge clk); while (!ar_ready_o);
    ar_valid_i <= 1'b0;
  endtask

  // single classic cycle, returns read data
  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdat);
    @(posedge clk);
    wb_i <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do @(posedge clk); while (!wb_o.ack);
    rdat = wb_o.dat;
    wb_i <= '0;
  endtask

  // drive queued vectors, both directions at once, then wait for all descriptors
  task automatic flush_and_drain();
    fork
      while (aw_q.size() != 0) send_aw(aw_q.pop_front());
      while (ar_q.size() != 0) send_ar(ar_q.pop_front());
    join
    while (exp_wr_q.size() != 0 || exp_rd_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    check("busy after drain", busy_o, 0);
  endtask

  // watchdog scaled by trace length
  initial begin
    wait (n_records != 0);
    repeat (200 * n_records) @(posedge clk);
    $display("timeout: the trace did not complete in time");
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog");
  end

  initial begin
    int          fd;
    string       line;
    string       kind;
    int          dir;
    logic [31:0] f_id, f_addr, f_len, f_size, f_dat, rdat;
    int          f_wr, f_last, f_spm, f_byp;
    bit          par;
    ax_chan_t    v;
    llc_desc_t   e;

    error_count  = 0;
    n_records    = 0;
    par          = 1'b0;
    held_stall   = 1'b0;
    rst_n_i      = 1'b0;
    aw_i         = '0;
    aw_valid_i   = 1'b0;
    ar_i         = '0;
    ar_valid_i   = 1'b0;
    desc_ready_i = 1'b0;
    wb_i         = '0;

    // first pass only counts records for the watchdog
    fd = $fopen("llc_split_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open llc_split_trace.txt");
      $display("Simulation finished: FAIL");
      $fatal(1, "no trace");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") n_records++;
    end
    $fclose(fd);
    fd = $fopen("llc_split_trace.txt", "r");

    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;
    @(posedge clk);
    check("busy after reset", busy_o, 0);
    check("aw_ready after reset", aw_ready_o, 1);
    check("ar_ready after reset", ar_ready_o, 1);

    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind == "#") begin
        void'($fgets(line, fd));
      end else if (kind == "W") begin
        flush_and_drain();
        par = 1'b0;
        void'($fscanf(fd, "%h %h", f_addr, f_dat));
        wb_access(1'b1, f_addr[1:0], f_dat, rdat);
        wb_access(1'b0, f_addr[1:0], 32'h0, rdat);
        check("register readback", rdat, f_dat);
      end else if (kind == "P") begin
        flush_and_drain();
        par = 1'b1;
      end else if (kind == "E") begin
        void'($fscanf(fd, "%d %h %h %h %d %d %d", f_wr, f_id, f_addr, f_len,
                      f_last, f_spm, f_byp));
        e = '{addr: f_addr, id: f_id[`LLC_ID_W-1:0], x_len: f_len[`LLC_LEN_W-1:0],
              x_last: f_last[0], x_write: f_wr[0], spm: f_spm[0], bypass: f_byp[0]};
        if (f_wr != 0) exp_wr_q.push_back(e);
        else exp_rd_q.push_back(e);
      end else if (kind == "V") begin
        void'($fscanf(fd, "%d %h %h %h %h", dir, f_id, f_addr, f_len, f_size));
        v = '{id: f_id[`LLC_ID_W-1:0], addr: f_addr, len: f_len[`LLC_LEN_W-1:0],
              size: f_size[2:0], burst: BURST_INCR};
        if (dir == 0) aw_q.push_back(v);
        else ar_q.push_back(v);
        if (!par) flush_and_drain();
      end else begin
        $display("unknown record kind %s in the trace", kind);
        $display("Simulation finished: FAIL");
        $fatal(1, "bad trace");
      end
    end
    flush_and_drain();
    $fclose(fd);

    if (error_count == 0 && exp_wr_q.size() == 0 && exp_rd_q.size() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: llc_split_trace.txt
# W reg data | V dir(0 aw,1 ar) id addr len size | E wr id addr x_len last spm bypass | P
# E lines of a vector come before its V line, P starts a parallel AW/AR section
E 1 1 00001000 07 1 0 0
V 0 1 00001000 07 2
E 0 2 00002018 01 0 0 0
E 0 2 00002020 07 1 0 0
V 1 2 00002018 09 2
E 1 3 00003010 03 0 0 0
E 1 3 00003020 07 0 0 0
E 1 3 00003040 07 1 0 0
V 0 3 00003010 13 2
W 1 40000000
W 2 C0000000
W 0 00000000
E 1 4 50000004 14 1 0 1
V 0 4 50000004 14 2
E 0 5 C0000000 03 1 1 0
V 1 5 C0000000 03 2
P
E 1 6 00000100 07 0 0 0
E 1 6 00000120 07 1 0 0
V 0 6 00000100 0f 2
E 0 7 00000208 05 1 0 0
V 1 7 00000208 05 2
E 0 8 0000031c 00 0 0 0
E 0 8 00000320 01 1 0 0
V 1 8 0000031c 02 3
E 1 9 00000400 00 1 0 0
V 0 9 00000400 00 2

// File: sim.f
+incdir+.
llc_axi_pkg.sv
llc_desc_pkg.sv
llc_burst_cutter.sv
llc_chan_splitter.sv
llc_desc_arbiter.sv
llc_addr_map_regs.sv
llc_split_top.sv
llc_split_assertions.sv
tb_llc_split.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_llc_split
RTL_TOP   := llc_split_top
FILELIST  := sim.f
FLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
